//--- dcache_tag_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache tag geometry, address field helpers
// and the structs shared by all tag stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package dcache_tag_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // geometry
    localparam int WAYS       = 4;
    localparam int LINES      = 64;
    localparam int LINE_W     = 6;
    localparam int SUB_LINE_W = 2;
    // whatever is left above the byte, word and set bits is tag
    localparam int TAG_W      = 32 - 2 - SUB_LINE_W - LINE_W;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address fields
    function automatic logic [TAG_W-1:0] get_tag(input logic [31:0] addr);
        return addr[2+SUB_LINE_W+LINE_W +: TAG_W];
    endfunction

    function automatic logic [LINE_W-1:0] get_line(input logic [31:0] addr);
        return addr[2+SUB_LINE_W +: LINE_W];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared types
    // one stored tag word, the valid bit sits on top
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } dtag_entry_t;

    typedef struct packed {
        logic [31:0] addr;
    } lookup_req_t;

    // refill target, way is one-hot
    typedef struct packed {
        logic [31:0]     addr;
        logic [WAYS-1:0] way;
    } fill_t;

    typedef struct packed {
        logic            hit;
        logic [WAYS-1:0] hit_way;
        logic [WAYS-1:0] victim_way;
    } lookup_resp_t;

    // decoded fields of the lookup sitting in stage 2
    typedef struct packed {
        logic [LINE_W-1:0] line;
        logic [TAG_W-1:0]  tag;
    } stage2_t;

endpackage

`default_nettype wire

//--- tag_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-port tag RAM for one way
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tag_bank #(
    parameter int WIDTH = 23,
    parameter int DEPTH = 64
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    // port A is the lookup read port
    input  wire logic                     en_a,
    input  wire logic [$clog2(DEPTH)-1:0] addr_a,
    output logic      [WIDTH-1:0]         data_out_a,
    // port B serves refills and snoop reads
    input  wire logic                     en_b,
    input  wire logic                     wen_b,
    input  wire logic [$clog2(DEPTH)-1:0] addr_b,
    input  wire logic [WIDTH-1:0]         data_in_b,
    output logic      [WIDTH-1:0]         data_out_b
);

    logic [WIDTH-1:0] mem [DEPTH];

    // both ports read first, so a read of a line written on the same edge
    // sees the old word
    always_ff @(posedge clk) begin
        if (en_b && wen_b) begin
            mem[addr_b] <= data_in_b;
        end
    end

    // outputs hold while their enable is low, which keeps a stalled lookup valid
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out_a <= '0;
            data_out_b <= '0;
        end else begin
            if (en_a) begin
                data_out_a <= mem[addr_a];
            end
            if (en_b) begin
                data_out_b <= mem[addr_b];
            end
        end
    end

endmodule

`default_nettype wire

//--- lookup_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lookup decode stage with the
// stage 2 address register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lookup_stage
    import dcache_tag_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    // request side
    input  wire logic              req_valid,
    input  wire lookup_req_t       req,
    output logic                   req_ready,
    // response handshake seen from the outside
    input  wire logic              resp_ready,
    // bank read port A
    output logic                   rd_en,
    output logic [LINE_W-1:0]      rd_line,
    // stage 2 contents
    output stage2_t                s2,
    output logic                   s2_valid,
    output logic                   resp_taken
);

    logic    accept;
    stage2_t decoded;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshakes
    // resp_valid is s2_valid, so the response leaves when stage 2 is full and
    // the outside is ready
    assign resp_taken = s2_valid & resp_ready;

    // stage 2 frees up on the same cycle its response goes out
    assign req_ready  = ~s2_valid | resp_taken;
    assign accept     = req_valid & req_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode
    assign decoded.line = get_line(req.addr);
    assign decoded.tag  = get_tag(req.addr);

    // the banks read only on acceptance so their outputs hold under a stall
    assign rd_en   = accept;
    assign rd_line = decoded.line;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2 register
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (accept) begin
            s2_valid <= 1'b1;
        end else if (resp_taken) begin
            s2_valid <= 1'b0;
        end
    end

    // the tag is needed one cycle later for the hit compare
    always_ff @(posedge clk) begin
        if (accept) begin
            s2 <= decoded;
        end
    end

endmodule

`default_nettype wire

//--- dtag_banks.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag banks of all ways, hit compare,
// refill write and snoop invalidation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dtag_banks
    import dcache_tag_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    // lookup read from the decode stage
    input  wire logic              rd_en,
    input  wire logic [LINE_W-1:0] rd_line,
    input  wire stage2_t           s2,
    // refill strobe
    input  wire logic              fill_valid,
    input  wire fill_t             fill,
    // snoop invalidation
    input  wire logic              inv_valid,
    input  wire logic [31:0]       inv_addr,
    output logic                   inv_done,
    output logic [WAYS-1:0]        hit_way
);

    dtag_entry_t       tag_a [WAYS];
    dtag_entry_t       tag_b [WAYS];
    dtag_entry_t       new_entry;
    dtag_entry_t       s2_cmp;
    dtag_entry_t       inv_cmp;
    logic [LINE_W-1:0] port_b_line;
    logic              port_b_en;
    logic              inv_owns_port;
    logic              inv_tags_read;
    logic [WAYS-1:0]   inv_hit_way;
    logic [WAYS-1:0]   wen_way;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port B arbitration
    // a refill always wins the port, the snoop only gets it on idle cycles
    assign port_b_en     = fill_valid | inv_valid;
    assign port_b_line   = fill_valid ? get_line(fill.addr) : get_line(inv_addr);
    assign inv_owns_port = inv_valid & ~fill_valid;

    // valid follows fill_valid, so a snoop write stores an invalid word
    assign new_entry.valid = fill_valid;
    assign new_entry.tag   = get_tag(fill.addr);

    // record that the snoop read its tags on the last edge
    // any refill in between throws the read away and the snoop starts over
    always_ff @(posedge clk) begin
        if (rst) begin
            inv_tags_read <= 1'b0;
        end else begin
            inv_tags_read <= inv_owns_port & ~inv_done;
        end
    end

    // second cycle with the port means tag_b now holds the snooped set
    assign inv_done = inv_owns_port & inv_tags_read;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare words, valid is forced to one so empty ways never match
    assign s2_cmp.valid  = 1'b1;
    assign s2_cmp.tag    = s2.tag;
    assign inv_cmp.valid = 1'b1;
    assign inv_cmp.tag   = get_tag(inv_addr);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one bank per way
    for (genvar i = 0; i < WAYS; i++) begin : g_way
        // refill writes its chosen way, the snoop clears every way it hit
        assign wen_way[i] = (fill_valid & fill.way[i]) | (inv_done & inv_hit_way[i]);

        tag_bank #(
            .WIDTH ($bits(dtag_entry_t)),
            .DEPTH (LINES)
        ) u_bank (
            .clk        (clk),
            .rst        (rst),
            .en_a       (rd_en),
            .addr_a     (rd_line),
            .data_out_a (tag_a[i]),
            .en_b       (port_b_en),
            .wen_b      (wen_way[i]),
            .addr_b     (port_b_line),
            .data_in_b  (new_entry),
            .data_out_b (tag_b[i])
        );

        assign inv_hit_way[i] = (tag_b[i] == inv_cmp);
        assign hit_way[i]     = (tag_a[i] == s2_cmp);
    end

endmodule

`default_nettype wire

//--- hit_result.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response stage with hit summary and
// round-robin victim choice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module hit_result
    import dcache_tag_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    // stage 2 status from the decode stage
    input  wire logic            s2_valid,
    input  wire logic            resp_taken,
    // per-way match from the banks
    input  wire logic [WAYS-1:0] hit_way,
    // response port
    output logic                 resp_valid,
    output lookup_resp_t         resp
);

    logic            hit;
    logic [WAYS-1:0] victim;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hit summary
    // at most one way can match a given tag, so the OR is enough
    assign hit = |hit_way;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // victim pointer
    // one-hot, starts at way 0 and steps only when a miss response leaves
    // hits leave it where it is
    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= WAYS'(1);
        end else if (resp_taken && !hit) begin
            victim <= {victim[WAYS-2:0], victim[WAYS-1]};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response
    // everything here is derived from held state, so it stays stable
    // while the outside stalls
    assign resp_valid      = s2_valid;
    assign resp.hit        = hit;
    assign resp.hit_way    = hit_way;
    // a hit reports the victim too but the refill logic only cares on a miss
    assign resp.victim_way = victim;

endmodule

`default_nettype wire

//--- dcache_tags.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache tag subsystem top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dcache_tags
    import dcache_tag_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    // lookup request
    input  wire logic        req_valid,
    input  wire lookup_req_t req,
    output logic             req_ready,
    // lookup response
    output logic             resp_valid,
    output lookup_resp_t     resp,
    input  wire logic        resp_ready,
    // refill strobe
    input  wire logic        fill_valid,
    input  wire fill_t       fill,
    // snoop invalidation
    input  wire logic        inv_valid,
    input  wire logic [31:0] inv_addr,
    output logic             inv_done
);

    logic              rd_en;
    logic [LINE_W-1:0] rd_line;
    stage2_t           s2;
    logic              s2_valid;
    logic              resp_taken;
    logic [WAYS-1:0]   hit_way;

    // decode stage, reads the banks on acceptance
    lookup_stage u_lookup (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_ready (resp_ready),
        .rd_en      (rd_en),
        .rd_line    (rd_line),
        .s2         (s2),
        .s2_valid   (s2_valid),
        .resp_taken (resp_taken)
    );

    // banks, compare and snoop sequencing
    dtag_banks u_banks (
        .clk        (clk),
        .rst        (rst),
        .rd_en      (rd_en),
        .rd_line    (rd_line),
        .s2         (s2),
        .fill_valid (fill_valid),
        .fill       (fill),
        .inv_valid  (inv_valid),
        .inv_addr   (inv_addr),
        .inv_done   (inv_done),
        .hit_way    (hit_way)
    );

    // response packing
    hit_result u_result (
        .clk        (clk),
        .rst        (rst),
        .s2_valid   (s2_valid),
        .resp_taken (resp_taken),
        .hit_way    (hit_way),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

//--- tb_dcache_tags_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake and snoop timing checks
// bound into the tag subsystem top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dcache_tags_assert
    import dcache_tag_pkg::*;
(
    input wire logic         clk,
    input wire logic         rst,
    input wire logic         req_valid,
    input wire lookup_req_t  req,
    input wire logic         req_ready,
    input wire logic         resp_valid,
    input wire lookup_resp_t resp,
    input wire logic         resp_ready,
    input wire logic         fill_valid,
    input wire logic         inv_valid,
    input wire logic         inv_done
);

    // number of failed checks so far
    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset state and lookup handshakes
    a_reset: assert property (@(posedge clk)
        $fell(rst) |-> req_ready && !resp_valid && !inv_done)
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else begin
            $error("request dropped or changed before acceptance");
            fail_count++;
        end

    // a stalled response must keep every field
    a_resp_stable: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else begin
            $error("response changed while stalled");
            fail_count++;
        end

    // distinct tags in a set mean no more than one way can match
    a_resp_shape: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> $onehot0(resp.hit_way))
        else begin
            $error("more than one way reported as hit");
            fail_count++;
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // snoop sequencing
    // two refill-free cycles after the snoop appears give inv_done on the second
    a_inv_time: assert property (@(posedge clk) disable iff (rst)
        ($rose(inv_valid) && !fill_valid) ##1 !fill_valid |-> inv_done)
        else begin
            $error("inv_done not on the second snoop cycle");
            fail_count++;
        end

endmodule

bind dcache_tags dcache_tags_assert u_check (.*);

`default_nettype wire

//--- tb_dcache_tags.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the tag subsystem with a
// reference tag model, watchdog and report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_tags
    import dcache_tag_pkg::*;
();

    localparam logic [31:0] SEED   = 32'h1252_8fac;
    localparam int          N_SETS = 4;
    localparam int          N_MISS = 8;
    localparam int          N_BP   = 40;
    // rough cycle budget per test where back-pressure lookups cost the most
    localparam int STIM_CYCLES = 4 + N_SETS*WAYS*2 + N_MISS*2 + 4*12 + N_BP*6 + 2*20;
    localparam int WATCHDOG_NS = (STIM_CYCLES + 100) * 4;

    logic         clk, rst, req_valid, req_ready, resp_valid, resp_ready;
    logic         fill_valid, inv_valid, inv_done, bp_on;
    lookup_req_t  req;
    lookup_resp_t resp;
    fill_t        fill;
    logic [31:0]  inv_addr, rnd_state, bp_state;

    // reference state with one entry per set and way
    dtag_entry_t       model [LINES][WAYS];
    lookup_resp_t      exp_q [$];
    logic [WAYS-1:0]   vic_ptr, last_victim;
    logic [LINE_W-1:0] sets [N_SETS];
    logic [31:0]       filled [N_SETS][WAYS];
    int                errors, tests_passed, tests_failed;

    dcache_tags UUT (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp(resp), .resp_ready(resp_ready),
        .fill_valid(fill_valid), .fill(fill),
        .inv_valid(inv_valid), .inv_addr(inv_addr), .inv_done(inv_done)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = lcg_next(rnd_state);
        return rnd_state;
    endfunction

    // the tag starts at bit 10 and the set sits in bits 9 to 4
    function automatic logic [TAG_W-1:0] addr_tag(input logic [31:0] a);
        return a[31:10];
    endfunction

    function automatic logic [LINE_W-1:0] addr_set(input logic [31:0] a);
        return a[9:4];
    endfunction

    // the low bits are filler that the lookup must ignore
    function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] t,
                                              input logic [LINE_W-1:0] s);
        return {t, s, t[3:0]};
    endfunction

    function automatic int onehot_index(input logic [WAYS-1:0] v);
        int idx;
        idx = 0;
        for (int i = 0; i < WAYS; i++) begin
            if (v[i]) idx = i;
        end
        return idx;
    endfunction

    function automatic int total_errors();
        return errors + UUT.u_check.fail_count;
    endfunction

    function automatic lookup_resp_t expect_lookup(input logic [31:0] a);
        lookup_resp_t      e;
        logic [LINE_W-1:0] s;
        e = '0;
        s = addr_set(a);
        for (int w = 0; w < WAYS; w++) begin
            e.hit_way[w] = model[s][w].valid && (model[s][w].tag == addr_tag(a));
        end
        e.hit = |e.hit_way;
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] got);
        if (expv !== got) begin
            errors++;
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expv, got);
        end
    endtask

    // the victim is whatever the pointer holds when the response leaves
    task automatic check_response();
        lookup_resp_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("response at %0t with no lookup pending", $time);
        end else begin
            e = exp_q.pop_front();
            compare_field("resp.hit", e.hit, resp.hit);
            compare_field("resp.hit_way", e.hit_way, resp.hit_way);
            compare_field("resp.victim_way", vic_ptr, resp.victim_way);
            if (!e.hit) begin
                last_victim = vic_ptr;
                vic_ptr     = {vic_ptr[WAYS-2:0], vic_ptr[WAYS-1]};
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock, back-pressure and monitor
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        bp_state   = lcg_next(SEED);
        resp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            bp_state   = lcg_next(bp_state);
            resp_ready = bp_on ? bp_state[16] : 1'b1;
        end
    end

    // inputs settle 1 ns after the edge, so the negedge sees what the next edge takes
    // lookups read the old contents, hence the model updates come last
    always @(negedge clk) begin
        if (!rst) begin
            if (resp_valid && resp_ready) check_response();
            if (req_valid && req_ready) exp_q.push_back(expect_lookup(req.addr));
            for (int w = 0; w < WAYS; w++) begin
                if (fill_valid && fill.way[w]) begin
                    model[addr_set(fill.addr)][w] = {1'b1, addr_tag(fill.addr)};
                end
                if (inv_done && model[addr_set(inv_addr)][w].valid
                        && model[addr_set(inv_addr)][w].tag == addr_tag(inv_addr)) begin
                    model[addr_set(inv_addr)][w].valid = 1'b0;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, run still busy after %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks
    task automatic fill_way(input logic [31:0] a, input int way);
        fill_valid = 1'b1;
        fill.addr  = a;
        fill.way   = WAYS'(1) << way;
        @(posedge clk);
        #1;
        fill_valid = 1'b0;
    endtask

    task automatic send_lookup(input logic [31:0] a);
        logic took;
        req_valid = 1'b1;
        req.addr  = a;
        do begin
            @(negedge clk);
            took = req_ready;
            @(posedge clk);
            #1;
        end while (!took);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // cycle 1 is the first cycle the snoop is visible
    task automatic snoop(input logic [31:0] a, input logic with_fill,
                         input logic [31:0] fa, input int fway, input int want);
        int   cycles;
        logic seen;
        inv_valid = 1'b1;
        inv_addr  = a;
        if (with_fill) begin
            fill_valid = 1'b1;
            fill.addr  = fa;
            fill.way   = WAYS'(1) << fway;
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 10) begin
            @(negedge clk);
            cycles++;
            seen = inv_done;
            @(posedge clk);
            #1;
            fill_valid = 1'b0;
        end
        inv_valid = 1'b0;
        if (!seen) begin
            errors++;
            $display("snoop of %h never finished", a);
        end else if (cycles != want) begin
            errors++;
            $display("snoop of %h finished after %0d cycles, %0d expected", a, cycles, want);
        end
    endtask

    task automatic finish_test(input string name, input int base);
        if (total_errors() == base) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, total_errors() - base);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    initial begin
        logic [31:0] r, a, b;
        int          s, w, base;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        fill_valid = 1'b0;
        fill = '0;
        inv_valid = 1'b0;
        inv_addr = '0;
        bp_on = 1'b0;
        rnd_state = SEED;
        vic_ptr = WAYS'(1);
        last_victim = WAYS'(1);
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < LINES; i++) begin
            for (int j = 0; j < WAYS; j++) begin
                model[i][j] = '0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        base = total_errors();
        @(posedge clk);
        #1;
        finish_test("reset state", base);

        // every way of each used set gets a known tag first
        base = total_errors();
        for (s = 0; s < N_SETS; s++) begin
            r = next_rand();
            sets[s] = LINE_W'(s * 16) | LINE_W'(r[3:0]);
            for (w = 0; w < WAYS; w++) begin
                r = next_rand();
                filled[s][w] = make_addr(r[TAG_W-1:0], sets[s]);
                fill_way(filled[s][w], w);
            end
        end
        for (s = 0; s < N_SETS; s++) begin
            for (w = 0; w < WAYS; w++) begin
                send_lookup(filled[s][w]);
            end
        end
        for (int i = 0; i < N_MISS; i++) begin
            r = next_rand();
            send_lookup(make_addr(r[TAG_W-1:0], sets[i % N_SETS]));
        end
        drain();
        finish_test("hit and miss", base);

        // refill into the reported victim, then look it up again
        base = total_errors();
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            a = make_addr(r[TAG_W-1:0], sets[i % N_SETS]);
            send_lookup(a);
            drain();
            w = onehot_index(last_victim);
            fill_way(a, w);
            filled[i % N_SETS][w] = a;
            send_lookup(a);
            drain();
        end
        finish_test("victim rotation", base);

        base = total_errors();
        bp_on = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            r = next_rand();
            s = r[5:4] % N_SETS;
            if (r[20]) begin
                send_lookup(filled[s][r[9:8]]);
            end else begin
                send_lookup(make_addr(r[31:10], sets[s]));
            end
        end
        drain();
        bp_on = 1'b0;
        finish_test("back-pressure", base);

        base = total_errors();
        a = filled[0][1];
        snoop(a, 1'b0, 32'h0, 0, 2);
        send_lookup(a);
        for (w = 0; w < WAYS; w++) begin
            if (w != 1) send_lookup(filled[0][w]);
        end
        drain();
        finish_test("snoop", base);

        // the refill in cycle 1 restarts the snoop, so it ends a cycle later
        base = total_errors();
        a = filled[1][2];
        r = next_rand();
        b = make_addr(r[TAG_W-1:0], sets[1]);
        snoop(a, 1'b1, b, 0, 3);
        filled[1][0] = b;
        send_lookup(a);
        send_lookup(b);
        drain();
        finish_test("snoop with refill", base);

        $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
dcache_tag_pkg.sv
tag_bank.sv
lookup_stage.sv
dtag_banks.sv
hit_result.sv
dcache_tags.sv
tb_dcache_tags_assert.sv
tb_dcache_tags.sv
